// ==== verilog/ics_defs.svh ====
////////////////////////////////////////
// Widths, address fields and register bit
// positions for the peripheral block.
// Included by the packages and the modules that decode fields.
////////////////////////////////////////

`ifndef ICS_DEFS_SVH
`define ICS_DEFS_SVH

// Bus and datapath widths
`define ICS_DATA_WIDTH 32
`define ICS_OPERAND_WIDTH 16
`define ICS_LED_WIDTH 8

// Peripheral region field of the address
`define ICS_REGION_MSB 23
`define ICS_REGION_LSB 20

// Region codes, also used as read select bit indices
`define ICS_REGION_STATUS 0
`define ICS_REGION_DSP 1
`define ICS_REGION_PAD 2
`define ICS_REGION_FLASH_CTRL 3

// Set for operand b of the multiplier
`define ICS_DSP_OPERAND_BIT 2

// Flash control write fields
`define ICS_FLASH_ACTIVE_BIT 15
`define ICS_FLASH_CSN_BIT 9
`define ICS_FLASH_CLK_BIT 8
`define ICS_FLASH_IN_EN_MSB 7
`define ICS_FLASH_IN_EN_LSB 4
`define ICS_FLASH_IN_MSB 3
`define ICS_FLASH_IN_LSB 0

`endif

// ==== verilog/ics_bus_pkg.sv ====
////////////////////////////////////////
// Types of the CPU-side memory bus.
// Imported by every module that sees the bus request.
////////////////////////////////////////

`include "ics_defs.svh"

package ics_bus_pkg;

    typedef logic [`ICS_DATA_WIDTH-1:0] addr_t;
    typedef logic [`ICS_DATA_WIDTH-1:0] data_t;

    // Any set bit marks a write, all clear a read
    typedef logic [3:0] wstrb_t;

    // Request as driven by the bus master
    typedef struct packed {
        logic mem_valid;
        addr_t address;
        wstrb_t wstrb;
        data_t write_data;
    } bus_req_t;

endpackage

// ==== verilog/ics_periph_pkg.sv ====
////////////////////////////////////////
// Types of the peripheral side: register
// fields, decoder strobes and flash pins.
////////////////////////////////////////

`include "ics_defs.svh"

package ics_periph_pkg;

    typedef logic signed [`ICS_OPERAND_WIDTH-1:0] operand_t;
    typedef logic signed [2*`ICS_OPERAND_WIDTH-1:0] product_t;

    typedef logic [`ICS_LED_WIDTH-1:0] led_t;
    typedef logic [1:0] pad_ctrl_t;
    typedef logic [3:0] nibble_t;
    typedef logic [`ICS_REGION_MSB-`ICS_REGION_LSB:0] region_t;

    // One-cycle strobes from the decoder
    typedef struct packed {
        logic status_we;
        logic dsp_we;
        logic pad_we;
        logic flash_we;
        // One-hot, indexed by region code
        logic [3:0] read_sel;
        logic respond;
    } periph_sel_t;

    typedef struct packed {
        logic [1:0] clk_ddr;
        logic csn;
        nibble_t flash_in;
        nibble_t flash_in_en;
    } flash_pins_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RELEASE
    } dec_state_t;

endpackage

// ==== verilog/periph_decoder.sv ====
////////////////////////////////////////
// Address decoder for the peripheral bus.
// Accepts one request per mem_valid assertion and issues
// one-cycle write strobes or a read select with respond.
////////////////////////////////////////

`include "ics_defs.svh"

module periph_decoder (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  ics_bus_pkg::bus_req_t bus_req,
    output ics_periph_pkg::periph_sel_t periph_sel,
    output ics_bus_pkg::data_t write_data,
    output logic operand_b_sel
);
    import ics_bus_pkg::*;
    import ics_periph_pkg::*;

    dec_state_t state;
    region_t region;
    logic is_write;
    logic [3:0] hit;
    periph_sel_t sel_next;
    logic accept;

    assign region = bus_req.address[`ICS_REGION_MSB:`ICS_REGION_LSB];
    assign is_write = bus_req.wstrb != wstrb_t'(0);
    assign accept = (state == IDLE) && bus_req.mem_valid;

    // Only the four low region codes are mapped
    assign hit = (region[3:2] == 2'b00) ? (4'b0001 << region[1:0]) : 4'b0000;

    always_comb begin
        sel_next = '0;
        sel_next.status_we = is_write & hit[`ICS_REGION_STATUS];
        sel_next.dsp_we = is_write & hit[`ICS_REGION_DSP];
        sel_next.pad_we = is_write & hit[`ICS_REGION_PAD];
        sel_next.flash_we = is_write & hit[`ICS_REGION_FLASH_CTRL];
        sel_next.read_sel = is_write ? 4'b0000 : hit;
        // Every accepted access completes, mapped or not
        sel_next.respond = 1'b1;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= IDLE;
            periph_sel <= '0;
        end else begin
            periph_sel <= '0;
            case (state)
                IDLE: begin
                    if (bus_req.mem_valid) begin
                        periph_sel <= sel_next;
                        state <= ACCESS;
                    end
                end
                ACCESS: state <= RELEASE;
                // Hold off until the master drops mem_valid
                RELEASE: begin
                    if (!bus_req.mem_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            write_data <= bus_req.write_data;
            operand_b_sel <= bus_req.address[`ICS_DSP_OPERAND_BIT];
        end
    end

endmodule

// ==== verilog/io_regs.sv ====
////////////////////////////////////////
// Status LEDs, gamepad control and direct
// flash pin control registers with their readback values.
////////////////////////////////////////

`include "ics_defs.svh"

module io_regs (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  ics_periph_pkg::periph_sel_t periph_sel,
    input  ics_bus_pkg::data_t write_data,
    input  logic [1:0] pad_data,
    input  ics_periph_pkg::nibble_t flash_out,
    output ics_periph_pkg::led_t led,
    output logic pad_latch,
    output logic pad_clk,
    output ics_periph_pkg::flash_pins_t flash,
    output ics_bus_pkg::data_t status_read,
    output ics_bus_pkg::data_t pad_read,
    output ics_bus_pkg::data_t flash_read
);
    import ics_bus_pkg::*;
    import ics_periph_pkg::*;

    led_t status;
    pad_ctrl_t pad_ctrl;
    logic flash_active;
    logic flash_clk;
    logic flash_csn;
    nibble_t flash_in;
    nibble_t flash_in_en;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= '0;
            pad_ctrl <= '0;
            flash_active <= 1'b0;
        end else begin
            if (periph_sel.status_we) begin
                status <= write_data[`ICS_LED_WIDTH-1:0];
            end
            if (periph_sel.pad_we) begin
                pad_ctrl <= write_data[1:0];
            end
            if (periph_sel.flash_we) begin
                flash_active <= write_data[`ICS_FLASH_ACTIVE_BIT];
            end
        end
    end

    // Pin values, only visible while direct control is active
    always_ff @(posedge vdp_clk) begin
        if (periph_sel.flash_we) begin
            flash_clk <= write_data[`ICS_FLASH_CLK_BIT];
            flash_csn <= write_data[`ICS_FLASH_CSN_BIT];
            flash_in <= write_data[`ICS_FLASH_IN_MSB:`ICS_FLASH_IN_LSB];
            flash_in_en <= write_data[`ICS_FLASH_IN_EN_MSB:`ICS_FLASH_IN_EN_LSB];
        end
    end

    always_comb begin
        if (flash_active) begin
            flash.clk_ddr = {2{flash_clk}};
            flash.csn = flash_csn;
            flash.flash_in = flash_in;
            flash.flash_in_en = flash_in_en;
        end else begin
            // Idle level: deselected, clock stopped, pins released
            flash.clk_ddr = 2'b00;
            flash.csn = 1'b1;
            flash.flash_in = '0;
            flash.flash_in_en = '0;
        end
    end

    assign led = status;
    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    // Status is write-only and reads back as zero
    assign status_read = '0;
    assign pad_read = data_t'(pad_data);
    assign flash_read = data_t'(flash_out);

endmodule

// ==== verilog/dsp_mult.sv ====
////////////////////////////////////////
// Signed 16x16 multiplier. Operands are
// written over the bus, the product is registered each cycle.
////////////////////////////////////////

`include "ics_defs.svh"

module dsp_mult (
    input  logic vdp_clk,
    input  ics_periph_pkg::periph_sel_t periph_sel,
    input  ics_bus_pkg::data_t write_data,
    input  logic operand_b_sel,
    output ics_periph_pkg::product_t product
);
    import ics_periph_pkg::*;

    operand_t operand_a;
    operand_t operand_b;

    // Flat load conditions so the operands map onto DSP input registers
    always_ff @(posedge vdp_clk) begin
        if (periph_sel.dsp_we && !operand_b_sel) begin
            operand_a <= write_data[`ICS_OPERAND_WIDTH-1:0];
        end

        if (periph_sel.dsp_we && operand_b_sel) begin
            operand_b <= write_data[`ICS_OPERAND_WIDTH-1:0];
        end

        product <= operand_a * operand_b;
    end

endmodule

// ==== verilog/bus_responder.sv ====
////////////////////////////////////////
// Read data mux and ready pulse back to the bus master.
////////////////////////////////////////

`include "ics_defs.svh"

module bus_responder (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  ics_periph_pkg::periph_sel_t periph_sel,
    input  ics_bus_pkg::data_t status_read,
    input  ics_bus_pkg::data_t pad_read,
    input  ics_bus_pkg::data_t flash_read,
    input  ics_periph_pkg::product_t product,
    output logic mem_ready,
    output ics_bus_pkg::data_t read_data
);
    import ics_bus_pkg::*;
    import ics_periph_pkg::*;

    data_t read_mux;

    // Zero for writes and unmapped regions
    always_comb begin
        if (periph_sel.read_sel[`ICS_REGION_STATUS]) begin
            read_mux = status_read;
        end else if (periph_sel.read_sel[`ICS_REGION_DSP]) begin
            read_mux = data_t'(product);
        end else if (periph_sel.read_sel[`ICS_REGION_PAD]) begin
            read_mux = pad_read;
        end else if (periph_sel.read_sel[`ICS_REGION_FLASH_CTRL]) begin
            read_mux = flash_read;
        end else begin
            read_mux = '0;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= periph_sel.respond;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (periph_sel.respond) begin
            read_data <= read_mux;
        end
    end

endmodule

// ==== verilog/ics_periph.sv ====
////////////////////////////////////////
// Peripheral block on the fast CPU bus.
// Decoder feeds the I/O registers and multiplier,
// the responder returns their read results.
////////////////////////////////////////

module ics_periph (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  ics_bus_pkg::bus_req_t bus_req,
    output logic mem_ready,
    output ics_bus_pkg::data_t read_data,
    output ics_periph_pkg::led_t led,
    output logic pad_latch,
    output logic pad_clk,
    input  logic [1:0] pad_data,
    output ics_periph_pkg::flash_pins_t flash,
    input  ics_periph_pkg::nibble_t flash_out
);

    ics_periph_pkg::periph_sel_t periph_sel;
    ics_bus_pkg::data_t write_data;
    logic operand_b_sel;

    ics_bus_pkg::data_t status_read;
    ics_bus_pkg::data_t pad_read;
    ics_bus_pkg::data_t flash_read;
    ics_periph_pkg::product_t product;

    periph_decoder decoder0 (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus_req(bus_req),
        .periph_sel(periph_sel),
        .write_data(write_data),
        .operand_b_sel(operand_b_sel)
    );

    io_regs io_regs0 (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .periph_sel(periph_sel),
        .write_data(write_data),
        .pad_data(pad_data),
        .flash_out(flash_out),
        .led(led),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .flash(flash),
        .status_read(status_read),
        .pad_read(pad_read),
        .flash_read(flash_read)
    );

    dsp_mult dsp_mult0 (
        .vdp_clk(vdp_clk),
        .periph_sel(periph_sel),
        .write_data(write_data),
        .operand_b_sel(operand_b_sel),
        .product(product)
    );

    bus_responder responder0 (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .periph_sel(periph_sel),
        .status_read(status_read),
        .pad_read(pad_read),
        .flash_read(flash_read),
        .product(product),
        .mem_ready(mem_ready),
        .read_data(read_data)
    );

endmodule

// ==== dv/ics_periph_properties.sv ====
////////////////////////////////////////
// Bus and flash pin properties of the peripheral block.
// Bound to every ics_periph instance.
////////////////////////////////////////

module ics_periph_properties (
    input logic vdp_clk,
    input logic vdp_reset,
    input ics_bus_pkg::bus_req_t bus_req,
    input logic mem_ready,
    input ics_periph_pkg::flash_pins_t flash
);
    timeunit 1ns;
    timeprecision 1ps;

    import ics_bus_pkg::*;
    import ics_periph_pkg::*;

    // Ready is a single-cycle pulse
    ready_single_cycle: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |=> !mem_ready)
        else $error("mem_ready held high for two cycles");

    ready_low_in_reset: assert property (@(posedge vdp_clk)
        vdp_reset |=> !mem_ready)
        else $error("mem_ready high while reset was applied");

    // Direct control is off right after reset
    flash_idle_after_reset: assert property (@(posedge vdp_clk)
        $fell(vdp_reset) |-> (flash.csn && flash.flash_in_en == '0))
        else $error("flash pins not idle after reset");

    ready_after_valid: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |-> $past(bus_req.mem_valid))
        else $error("mem_ready without a preceding mem_valid");

endmodule

bind ics_periph ics_periph_properties props0 (
    .vdp_clk(vdp_clk),
    .vdp_reset(vdp_reset),
    .bus_req(bus_req),
    .mem_ready(mem_ready),
    .flash(flash)
);

// ==== dv/tb_ics_periph.sv ====
////////////////////////////////////////
// Directed testbench for the peripheral block.
// Drives bus accesses on falling edges and checks
// LED, DSP, gamepad and flash behavior.
////////////////////////////////////////

`include "ics_defs.svh"

module tb_ics_periph;
    timeunit 1ns;
    timeprecision 1ps;

    import ics_bus_pkg::*;
    import ics_periph_pkg::*;

    localparam int READY_TIMEOUT = 20;

    logic vdp_clk;
    logic vdp_reset;
    bus_req_t bus_req;
    logic mem_ready;
    data_t read_data;
    led_t led;
    logic pad_latch;
    logic pad_clk;
    logic [1:0] pad_data;
    flash_pins_t flash;
    nibble_t flash_out;

    int check_errors = 0;
    int timeout_errors = 0;
    logic [31:0] lcg_state = 32'd7;

    ics_periph dut0 (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus_req(bus_req),
        .mem_ready(mem_ready),
        .read_data(read_data),
        .led(led),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .pad_data(pad_data),
        .flash(flash),
        .flash_out(flash_out)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #10 vdp_clk = ~vdp_clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic addr_t make_addr(input int region, input logic operand_b);
        addr_t addr;
        addr = '0;
        addr[`ICS_REGION_MSB:`ICS_REGION_LSB] = region[3:0];
        addr[`ICS_DSP_OPERAND_BIT] = operand_b;
        return addr;
    endfunction

    task automatic check_data(input string test_name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_led(input string test_name, input led_t expected, input led_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_flash(input string test_name, input flash_pins_t expected,
                               input flash_pins_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
            check_errors++;
        end
    endtask

    // One bus access, holding mem_valid until ready or timeout
    task automatic transfer(input addr_t address, input wstrb_t wstrb, input data_t wdata,
                            output data_t rdata);
        int cycles;
        logic done;
        rdata = '0;
        done = 1'b0;
        cycles = 0;
        @(negedge vdp_clk);
        bus_req.address = address;
        bus_req.wstrb = wstrb;
        bus_req.write_data = wdata;
        bus_req.mem_valid = 1'b1;
        while (!done && cycles < READY_TIMEOUT) begin
            @(negedge vdp_clk);
            cycles++;
            if (mem_ready) begin
                done = 1'b1;
                rdata = read_data;
            end
        end
        bus_req.mem_valid = 1'b0;
        if (!done) begin
            $display("No mem_ready within %0d cycles for address %h", READY_TIMEOUT, address);
            timeout_errors++;
        end
    endtask

    task automatic bus_write(input addr_t address, input data_t wdata);
        data_t unused;
        transfer(address, 4'hF, wdata, unused);
    endtask

    task automatic bus_read(input addr_t address, output data_t rdata);
        transfer(address, 4'h0, '0, rdata);
    endtask

    function automatic flash_pins_t idle_pins();
        flash_pins_t pins;
        pins.clk_ddr = 2'b00;
        pins.csn = 1'b1;
        pins.flash_in = '0;
        pins.flash_in_en = '0;
        return pins;
    endfunction

    task automatic reset_values();
        data_t rd;
        check_led("reset_values", '0, led);
        check_data("reset_values", '0, data_t'({pad_clk, pad_latch}));
        check_flash("reset_values", idle_pins(), flash);
        bus_read(make_addr(`ICS_REGION_STATUS, 1'b0), rd);
        check_data("reset_values", '0, rd);
    endtask

    task automatic led_write();
        data_t pattern;
        data_t rd;
        repeat (4) begin
            pattern = next_rand();
            bus_write(make_addr(`ICS_REGION_STATUS, 1'b0), pattern);
            check_led("led_write", pattern[`ICS_LED_WIDTH-1:0], led);
        end
        // Region 9 is not mapped
        bus_read(make_addr(9, 1'b0), rd);
        check_data("led_write", '0, rd);
    endtask

    task automatic dsp_multiply();
        logic [31:0] r;
        operand_t a;
        operand_t b;
        product_t expected;
        data_t rd;
        for (int i = 0; i < 6; i++) begin
            r = next_rand();
            a = r[15:0];
            b = r[31:16];
            // Force a negative operand, then two
            if (i == 0) a[15] = 1'b1;
            if (i == 1) begin
                a[15] = 1'b1;
                b[15] = 1'b1;
            end
            bus_write(make_addr(`ICS_REGION_DSP, 1'b0), {16'h0000, a});
            bus_write(make_addr(`ICS_REGION_DSP, 1'b1), {16'h0000, b});
            expected = product_t'(a) * product_t'(b);
            bus_read(make_addr(`ICS_REGION_DSP, 1'b0), rd);
            check_data("dsp_multiply", data_t'(expected), rd);
        end
    endtask

    task automatic pad_io();
        logic [31:0] r;
        data_t rd;
        repeat (4) begin
            r = next_rand();
            bus_write(make_addr(`ICS_REGION_PAD, 1'b0), r);
            check_data("pad_io", data_t'(r[1:0]), data_t'({pad_clk, pad_latch}));
            pad_data = r[17:16];
            bus_read(make_addr(`ICS_REGION_PAD, 1'b0), rd);
            check_data("pad_io", data_t'(r[17:16]), rd);
        end
    endtask

    task automatic flash_control();
        logic [31:0] r;
        flash_pins_t expected;
        data_t rd;
        repeat (3) begin
            r = next_rand();
            r[`ICS_FLASH_ACTIVE_BIT] = 1'b1;
            bus_write(make_addr(`ICS_REGION_FLASH_CTRL, 1'b0), r);
            expected.clk_ddr = {2{r[`ICS_FLASH_CLK_BIT]}};
            expected.csn = r[`ICS_FLASH_CSN_BIT];
            expected.flash_in = r[`ICS_FLASH_IN_MSB:`ICS_FLASH_IN_LSB];
            expected.flash_in_en = r[`ICS_FLASH_IN_EN_MSB:`ICS_FLASH_IN_EN_LSB];
            check_flash("flash_control", expected, flash);
            flash_out = r[19:16];
            bus_read(make_addr(`ICS_REGION_FLASH_CTRL, 1'b0), rd);
            check_data("flash_control", data_t'(r[19:16]), rd);
            r[`ICS_FLASH_ACTIVE_BIT] = 1'b0;
            bus_write(make_addr(`ICS_REGION_FLASH_CTRL, 1'b0), r);
            check_flash("flash_control", idle_pins(), flash);
        end
    endtask

    initial begin
        bus_req = '0;
        pad_data = 2'b00;
        flash_out = '0;
        vdp_reset = 1'b1;
        repeat (3) @(negedge vdp_clk);
        vdp_reset = 1'b0;

        reset_values();
        led_write();
        dsp_multiply();
        pad_io();
        flash_control();

        $display("Errors: %0d value mismatches, %0d ready timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/ics_bus_pkg.sv
verilog/ics_periph_pkg.sv
verilog/periph_decoder.sv
verilog/io_regs.sv
verilog/dsp_mult.sv
verilog/bus_responder.sv
verilog/ics_periph.sv
dv/ics_periph_properties.sv
dv/tb_ics_periph.sv

// ==== run.sh ====
#!/bin/sh
# Build the peripheral block testbench with Verilator and run it.
# The run fails unless the testbench prints its pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module tb_ics_periph \
    -o sim_ics_periph

sim_out=$(./obj_dir/sim_ics_periph)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'TEST PASSED'; then
    exit 0
fi
exit 1
